//--- Makefile
# Verilator flow for the Euler ODE solver

VERILATOR  ?= verilator
TOP        := tb_ode_solver
FLIST      := flist.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST)

# the binary exits non-zero on $fatal, which fails this target
sim: build
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
+incdir+rtl
rtl/ode_pkg.sv
rtl/fix_mul.sv
rtl/fix_add.sv
rtl/ode_step_pipe.sv
rtl/ode_control.sv
rtl/ode_solver.sv
sim/tb_ode_solver.sv

//--- rtl/fix_add.sv
// Saturating fixed-point adder
`timescale 1ns/1ps
`include "ode_config.svh"

module fix_add (
	input logic clock,
	input logic rst,
	input logic in_valid,
	input ode_pkg::fixed_t a,
	input ode_pkg::fixed_t b,
	output logic out_valid,
	output ode_pkg::fixed_t s
);

	localparam int msb = `ODE_WIDTH - 1;

	ode_pkg::fixed_t raw;
	logic ovf;

	// wrapping sum
	assign raw = a + b;

	// overflow only when both operands share a sign the sum lost
	assign ovf = (a[msb] == b[msb]) && (raw[msb] != a[msb]);

	always_ff @(posedge clock)
	begin
		if (!ovf)
			s <= raw;
		else if (a[msb])
			s <= ode_pkg::fixed_min;
		else
			s <= ode_pkg::fixed_max;
	end

	always_ff @(posedge clock)
	begin
		if (rst)
			out_valid <= 1'b0;
		else
			out_valid <= in_valid;
	end

	a_add_sign: assert property (@(posedge clock) disable iff (rst)
		in_valid && (a[msb] == b[msb]) |=> (s[msb] == $past(a[msb])))
		else $error("fix_add sum flipped the sign of like-signed operands");

endmodule

//--- rtl/fix_mul.sv
// Saturating fixed-point multiplier
`timescale 1ns/1ps
`include "ode_config.svh"

module fix_mul (
	input logic clock,
	input logic rst,
	input logic in_valid,
	input ode_pkg::fixed_t a,
	input ode_pkg::fixed_t b,
	output logic out_valid,
	output ode_pkg::fixed_t p
);

	localparam int prod_w = 2 * `ODE_WIDTH;

	logic signed [prod_w-1:0] prod_q;
	logic signed [prod_w-1:0] shifted;
	logic [`ODE_MUL_STAGES-1:0] vld_q;
	logic fits;
	ode_pkg::fixed_t sat;

	// stage one, full product
	always_ff @(posedge clock)
		prod_q <= prod_w'(a) * prod_w'(b);

	// drop the extra fraction bits, rounding toward minus infinity
	assign shifted = prod_q >>> `ODE_FRAC;

	// result fits when all bits above the word are copies of its sign
	assign fits = (&shifted[prod_w-1:`ODE_WIDTH-1]) || !(|shifted[prod_w-1:`ODE_WIDTH-1]);

	always_comb
	begin
		if (fits)
			sat = shifted[`ODE_WIDTH-1:0];
		else if (shifted[prod_w-1])
			sat = ode_pkg::fixed_min;
		else
			sat = ode_pkg::fixed_max;
	end

	// stage two, clamped result
	always_ff @(posedge clock)
		p <= sat;

	always_ff @(posedge clock)
	begin
		if (rst)
			vld_q <= '0;
		else
			vld_q <= {vld_q[`ODE_MUL_STAGES-2:0], in_valid};
	end

	assign out_valid = vld_q[`ODE_MUL_STAGES-1];

	a_mul_latency: assert property (@(posedge clock) disable iff (rst)
		in_valid |-> ##(`ODE_MUL_STAGES) out_valid)
		else $error("fix_mul result tag missing after %0d cycles", `ODE_MUL_STAGES);

endmodule

//--- rtl/ode_config.svh
// Euler solver configuration
`ifndef ODE_CONFIG_SVH
`define ODE_CONFIG_SVH

// word width of every Q16.16 value
`define ODE_WIDTH 32

// fraction bits in the fixed-point format
`define ODE_FRAC 16

// multiplier pipeline depth
`define ODE_MUL_STAGES 2

// step pipe latency through both multiplies and the y add
`define ODE_STEP_LAT 5

// width of the step counter in a command
`define ODE_STEP_BITS 16

`endif

//--- rtl/ode_control.sv
// Euler solver controller
`timescale 1ns/1ps
`include "ode_config.svh"

module ode_control (
	input logic clock,
	input logic rst,
	input logic cmd_valid,
	input ode_pkg::ode_cmd_t cmd,
	output logic step_valid,
	output ode_pkg::step_op_t step_in,
	input logic out_valid,
	input ode_pkg::ode_state_t step_out,
	output logic result_valid,
	output logic done,
	output logic busy,
	output ode_pkg::ode_state_t result
);

	typedef enum logic [1:0] {
		st_idle,
		st_issue,
		st_wait
	} ctrl_state_e;

	ctrl_state_e state_q;
	ctrl_state_e state_d;
	ode_pkg::ode_state_t init_q;
	ode_pkg::fixed_t h_q;
	ode_pkg::fixed_t k_q;
	logic [`ODE_STEP_BITS-1:0] count_q;
	logic accept;
	logic zero_steps;
	logic last_step;

	// new commands only land when idle
	assign accept = (state_q == st_idle) && cmd_valid;
	assign zero_steps = (count_q == '0);
	assign last_step = (count_q == {{(`ODE_STEP_BITS-1){1'b0}}, 1'b1});

	always_comb
	begin
		state_d = state_q;
		step_valid = 1'b0;
		result_valid = 1'b0;
		done = 1'b0;
		case (state_q)
			st_idle:
			begin
				if (cmd_valid)
					state_d = st_issue;
			end
			st_issue:
			begin
				if (zero_steps)
				begin
					done = 1'b1;
					state_d = st_idle;
				end
				else
				begin
					step_valid = 1'b1;
					state_d = st_wait;
				end
			end
			st_wait:
			begin
				// a returning result immediately launches the next step
				if (out_valid)
				begin
					result_valid = 1'b1;
					if (last_step)
					begin
						done = 1'b1;
						state_d = st_idle;
					end
					else
						step_valid = 1'b1;
				end
			end
			default:
				state_d = st_idle;
		endcase
	end

	// first step from the command, then from the pipe output
	always_comb
	begin
		step_in.h = h_q;
		step_in.k = k_q;
		if (state_q == st_issue)
			step_in.state = init_q;
		else
			step_in.state = step_out;
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			state_q <= st_idle;
			count_q <= '0;
		end
		else
		begin
			state_q <= state_d;
			if (accept)
				count_q <= cmd.steps;
			else if (result_valid)
				count_q <= count_q - 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			init_q <= cmd.init;
			h_q <= cmd.h;
			k_q <= cmd.k;
		end
	end

	assign busy = (state_q != st_idle);
	assign result = step_out;

	// one trajectory at a time so no issue until the pipe has drained
	a_one_in_flight: assert property (@(posedge clock) disable iff (rst)
		step_valid |=> (!step_valid) [*(`ODE_STEP_LAT-1)])
		else $error("step issued while another step is in flight");

	// done ends a busy trajectory with every step used up
	a_done_busy: assert property (@(posedge clock) disable iff (rst)
		done |-> busy ##1 (count_q == '0))
		else $error("done raised outside a busy trajectory or with steps left");

endmodule

//--- rtl/ode_pkg.sv
// Euler solver types
`include "ode_config.svh"

package ode_pkg;

	// signed Q16.16 scalar
	typedef logic signed [`ODE_WIDTH-1:0] fixed_t;

	// saturation limits
	localparam fixed_t fixed_max = {1'b0, {(`ODE_WIDTH-1){1'b1}}};
	localparam fixed_t fixed_min = {1'b1, {(`ODE_WIDTH-1){1'b0}}};

	// solution point
	typedef struct packed {
		fixed_t y;
		fixed_t t;
	} ode_state_t;

	// operands of one Euler step
	typedef struct packed {
		ode_state_t state;
		fixed_t h;
		fixed_t k;
	} step_op_t;

	// one trajectory request
	typedef struct packed {
		ode_state_t init;
		fixed_t h;
		fixed_t k;
		logic [`ODE_STEP_BITS-1:0] steps;
	} ode_cmd_t;

endpackage

//--- rtl/ode_solver.sv
// Euler ODE solver top
`timescale 1ns/1ps

module ode_solver (
	input logic clock,
	input logic rst,
	input logic cmd_valid,
	input ode_pkg::ode_cmd_t cmd,
	output logic result_valid,
	output logic done,
	output logic busy,
	output ode_pkg::ode_state_t result
);

	logic step_valid;
	logic out_valid;
	ode_pkg::step_op_t step_in;
	ode_pkg::ode_state_t step_out;

	ode_control control (
		.clock(clock),
		.rst(rst),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.step_valid(step_valid),
		.step_in(step_in),
		.out_valid(out_valid),
		.step_out(step_out),
		.result_valid(result_valid),
		.done(done),
		.busy(busy),
		.result(result)
	);

	ode_step_pipe step_pipe (
		.clock(clock),
		.rst(rst),
		.step_valid(step_valid),
		.step_in(step_in),
		.out_valid(out_valid),
		.step_out(step_out)
	);

endmodule

//--- rtl/ode_step_pipe.sv
// Euler step datapath
`timescale 1ns/1ps
`include "ode_config.svh"

module ode_step_pipe (
	input logic clock,
	input logic rst,
	input logic step_valid,
	input ode_pkg::step_op_t step_in,
	output logic out_valid,
	output ode_pkg::ode_state_t step_out
);

	// difference waits for h*k, y waits for both multiplies
	localparam int d_depth = `ODE_MUL_STAGES - 1;
	localparam int y_depth = 2 * `ODE_MUL_STAGES;
	localparam int t_depth = `ODE_STEP_LAT - 1;

	ode_pkg::fixed_t neg_y;
	ode_pkg::fixed_t factor;
	ode_pkg::fixed_t diff;
	ode_pkg::fixed_t prod;
	ode_pkg::fixed_t sum;
	ode_pkg::fixed_t t_next;
	logic factor_valid;
	logic diff_valid;
	logic prod_valid;
	logic sum_valid;
	logic t_next_valid;

	ode_pkg::fixed_t diff_dly [d_depth];
	ode_pkg::fixed_t y_dly [y_depth];
	ode_pkg::fixed_t t_dly [t_depth];
	logic [d_depth-1:0] diff_vld;
	logic [y_depth-1:0] y_vld;
	logic [t_depth-1:0] t_vld;

	// -y with the one unrepresentable case clamped
	always_comb
	begin
		if (step_in.state.y == ode_pkg::fixed_min)
			neg_y = ode_pkg::fixed_max;
		else
			neg_y = -step_in.state.y;
	end

	// h*k
	fix_mul factor_mul (
		.clock(clock),
		.rst(rst),
		.in_valid(step_valid),
		.a(step_in.h),
		.b(step_in.k),
		.out_valid(factor_valid),
		.p(factor)
	);

	// t - y
	fix_add diff_add (
		.clock(clock),
		.rst(rst),
		.in_valid(step_valid),
		.a(step_in.state.t),
		.b(neg_y),
		.out_valid(diff_valid),
		.s(diff)
	);

	// slope times step
	fix_mul slope_mul (
		.clock(clock),
		.rst(rst),
		.in_valid(factor_valid & diff_vld[d_depth-1]),
		.a(factor),
		.b(diff_dly[d_depth-1]),
		.out_valid(prod_valid),
		.p(prod)
	);

	fix_add y_add (
		.clock(clock),
		.rst(rst),
		.in_valid(prod_valid & y_vld[y_depth-1]),
		.a(y_dly[y_depth-1]),
		.b(prod),
		.out_valid(sum_valid),
		.s(sum)
	);

	fix_add t_add (
		.clock(clock),
		.rst(rst),
		.in_valid(step_valid),
		.a(step_in.state.t),
		.b(step_in.h),
		.out_valid(t_next_valid),
		.s(t_next)
	);

	// delay line payloads
	always_ff @(posedge clock)
	begin
		diff_dly[0] <= diff;
		y_dly[0] <= step_in.state.y;
		t_dly[0] <= t_next;
		for (int i = 1; i < d_depth; i++)
		begin
			diff_dly[i] <= diff_dly[i-1];
		end
		for (int i = 1; i < y_depth; i++)
		begin
			y_dly[i] <= y_dly[i-1];
		end
		for (int i = 1; i < t_depth; i++)
		begin
			t_dly[i] <= t_dly[i-1];
		end
	end

	// valid bits ride along with each entry
	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			diff_vld <= '0;
			y_vld <= '0;
			t_vld <= '0;
		end
		else
		begin
			diff_vld[0] <= diff_valid;
			y_vld[0] <= step_valid;
			t_vld[0] <= t_next_valid;
			for (int i = 1; i < d_depth; i++)
			begin
				diff_vld[i] <= diff_vld[i-1];
			end
			for (int i = 1; i < y_depth; i++)
			begin
				y_vld[i] <= y_vld[i-1];
			end
			for (int i = 1; i < t_depth; i++)
			begin
				t_vld[i] <= t_vld[i-1];
			end
		end
	end

	assign out_valid = sum_valid & t_vld[t_depth-1];
	assign step_out.y = sum;
	assign step_out.t = t_dly[t_depth-1];

	a_pipe_latency: assert property (@(posedge clock) disable iff (rst)
		step_valid |-> ##(`ODE_STEP_LAT) out_valid)
		else $error("step pipe result missing after %0d cycles", `ODE_STEP_LAT);

endmodule

//--- sim/tb_ode_solver.sv
// Euler ODE solver testbench
`timescale 1ns/1ps
`include "ode_config.svh"

module tb_ode_solver;

	localparam longint word_max = 64'sd2147483647;
	localparam longint word_min = -64'sd2147483648;
	localparam int wait_limit = 200;

	logic clock = 1'b0;
	logic rst;
	logic cmd_valid;
	ode_pkg::ode_cmd_t cmd;
	logic result_valid;
	logic done;
	logic busy;
	ode_pkg::ode_state_t result;

	// expected trajectory of the accepted command
	ode_pkg::fixed_t exp_y [64];
	ode_pkg::fixed_t exp_t [64];
	int exp_steps = 0;
	int cmd_cyc = 0;
	int done_target = 0;

	// observed by the checker
	int cyc = 0;
	int res_cnt = 0;
	int done_cnt = 0;

	logic [31:0] rand_state = 32'hcb8a;

	ode_solver UUT (
		.clock(clock),
		.rst(rst),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.result_valid(result_valid),
		.done(done),
		.busy(busy),
		.result(result)
	);

	always #4 clock = ~clock;

	always @(posedge clock)
		cyc <= cyc + 1;

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		$display("FAIL time %0t %s got %h expected %h", $time, name, got, expected);
		$display(">>> FAIL");
		$fatal(1, "value mismatch on %s", name);
	endtask

	task automatic abort_run(input string msg);
		$display("%s at time %0t", msg, $time);
		$display(">>> FAIL");
		$fatal(1, "%s", msg);
	endtask

	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rand_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rand_state = x;
		return x;
	endfunction

	// model arithmetic in 64 bits, then clamp to one word
	function automatic ode_pkg::fixed_t clamp_word(input longint v);
		if (v > word_max)
			return 32'h7fff_ffff;
		if (v < word_min)
			return 32'h8000_0000;
		return v[31:0];
	endfunction

	function automatic ode_pkg::fixed_t model_add(input ode_pkg::fixed_t a,
		input ode_pkg::fixed_t b);
		return clamp_word(longint'(a) + longint'(b));
	endfunction

	function automatic ode_pkg::fixed_t model_mul(input ode_pkg::fixed_t a,
		input ode_pkg::fixed_t b);
		longint full;
		full = longint'(a) * longint'(b);
		return clamp_word(full >>> `ODE_FRAC);
	endfunction

	function automatic ode_pkg::fixed_t model_neg(input ode_pkg::fixed_t a);
		return clamp_word(-longint'(a));
	endfunction

	function automatic ode_pkg::ode_cmd_t pack_command(input logic [31:0] y,
		input logic [31:0] t, input logic [31:0] h, input logic [31:0] k, input int steps);
		ode_pkg::ode_cmd_t c;
		c.init.y = y;
		c.init.t = t;
		c.h = h;
		c.k = k;
		c.steps = 16'(steps);
		return c;
	endfunction

	// y and t about +-8.0, h and k in [0, 1)
	function automatic ode_pkg::ode_cmd_t random_command(input int steps);
		logic [31:0] ry;
		logic [31:0] rt;
		logic [31:0] rh;
		logic [31:0] rk;
		ry = next_rand();
		rt = next_rand();
		rh = next_rand();
		rk = next_rand();
		return pack_command({{12{ry[19]}}, ry[19:0]}, {{12{rt[19]}}, rt[19:0]},
			{16'h0000, rh[15:0]}, {16'h0000, rk[15:0]}, steps);
	endfunction

	// reference model fills the trajectory, then the command is pulsed
	task automatic issue_command(input ode_pkg::ode_cmd_t c);
		ode_pkg::fixed_t y;
		ode_pkg::fixed_t t;
		ode_pkg::fixed_t slope;
		y = c.init.y;
		t = c.init.t;
		for (int i = 0; i < int'(c.steps); i++)
		begin
			slope = model_mul(model_mul(c.h, c.k), model_add(t, model_neg(y)));
			y = model_add(y, slope);
			t = model_add(t, c.h);
			exp_y[i] = y;
			exp_t[i] = t;
		end
		exp_steps = int'(c.steps);
		cmd_cyc = cyc;
		done_target = done_target + 1;
		cmd = c;
		cmd_valid = 1'b1;
		@(posedge clock);
		#1;
		cmd_valid = 1'b0;
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		do
		begin
			@(posedge clock);
			#1;
			n++;
			if (n > wait_limit)
				abort_run("timed out waiting for the solver to go idle");
		end
		while (busy);
	endtask

	// cycle-exact checker against the recorded command
	always @(posedge clock)
	begin
		logic busy_exp;
		logic rv_exp;
		logic done_exp;
		if (rst)
		begin
			res_cnt <= 0;
			done_cnt <= 0;
		end
		else
		begin
			busy_exp = (cyc > cmd_cyc) && (done_cnt < done_target);
			rv_exp = busy_exp && (res_cnt < exp_steps)
				&& (cyc == cmd_cyc + 1 + `ODE_STEP_LAT * (res_cnt + 1));
			if (exp_steps == 0)
				done_exp = busy_exp && (cyc == cmd_cyc + 1);
			else
				done_exp = rv_exp && (res_cnt == exp_steps - 1);
			assert (busy == busy_exp)
			else
				report_mismatch("busy", 32'(busy), 32'(busy_exp));
			assert (result_valid == rv_exp)
			else
				report_mismatch("result_valid", 32'(result_valid), 32'(rv_exp));
			assert (done == done_exp)
			else
				report_mismatch("done", 32'(done), 32'(done_exp));
			if (result_valid)
			begin
				assert (result.y == exp_y[res_cnt])
				else
					report_mismatch("result.y", result.y, exp_y[res_cnt]);
				assert (result.t == exp_t[res_cnt])
				else
					report_mismatch("result.t", result.t, exp_t[res_cnt]);
				res_cnt <= res_cnt + 1;
			end
			// accepted command restarts the step index
			if (cmd_valid && !busy)
				res_cnt <= 0;
			if (done)
				done_cnt <= done_cnt + 1;
		end
	end

	a_busy_drop: assert property (@(posedge clock) disable iff (rst)
		done |=> !busy)
		else abort_run("busy stayed high after done");

	a_busy_start: assert property (@(posedge clock) disable iff (rst)
		$rose(busy) |-> $past(cmd_valid))
		else abort_run("busy rose without a command");

	initial
	begin
		rst = 1'b1;
		cmd_valid = 1'b0;
		cmd = '0;
		repeat (3) @(posedge clock);
		#1;
		rst = 1'b0;

		// quiet outputs before any command
		repeat (6) @(posedge clock);
		#1;

		for (int n = 0; n < 12; n++)
		begin
			issue_command(random_command(int'(next_rand() % 32'd10) + 1));
			wait_idle();
		end

		// second command lands mid-trajectory and must be dropped
		issue_command(random_command(4));
		repeat (7) @(posedge clock);
		#1;
		if (!busy)
			abort_run("solver was not busy when the extra command was sent");
		cmd = random_command(6);
		cmd_valid = 1'b1;
		@(posedge clock);
		#1;
		cmd_valid = 1'b0;
		wait_idle();

		issue_command(random_command(0));
		wait_idle();

		// saturation corners
		issue_command(pack_command(32'h8000_0100, 32'h7f00_0000, 32'h0000_c000,
			32'h0002_0000, 3));
		wait_idle();
		issue_command(pack_command(32'h8000_0000, 32'h7fff_0000, 32'h0001_0000,
			32'h0008_0000, 2));
		wait_idle();
		issue_command(pack_command(32'h7fff_0000, 32'h8000_0000, 32'h0000_8000,
			32'h0004_0000, 3));
		wait_idle();

		repeat (3) @(posedge clock);
		#1;
		$display(">>> PASS");
		$finish;
	end

endmodule
